/* include/trace_cfg.svh */
`ifndef TRACE_CFG_SVH
`define TRACE_CFG_SVH

// Clock cycles per serial bit
`define TRACE_BAUD_DIV 16'd8

// Idle cycles before each FIFO read
`define TRACE_GAP_CYCLES 32'd12

// One step worth of records
`define TRACE_FIFO_RECORDS 4

`endif

/* design/trace_pkg.sv */
package trace_pkg;

	typedef logic [7:0] char_t;

	// Eight characters, first one out in the top byte
	typedef logic [63:0] record_t;

	typedef logic [3:0] nibble_t;

	localparam char_t CHAR_ZERO = 8'h30;
	// 'A' minus ten
	localparam char_t CHAR_ALPHA_BASE = 8'h37;
	localparam char_t CHAR_CR = 8'h0d;
	localparam char_t CHAR_LF = 8'h0a;

	typedef enum logic [2:0] {
		IDLE,
		INSTR,
		ADDR,
		DATA,
		TAIL
	} step_state_t;

endpackage

/* design/uart_pkg.sv */
package uart_pkg;

	// Start, eight data bits, stop
	localparam int FRAME_BITS = 10;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_SHIFT,
		TX_STOP
	} tx_state_t;

	typedef enum logic [1:0] {
		SEND_IDLE,
		SEND_GAP,
		SEND_POP,
		SEND_START
	} send_state_t;

endpackage

/* design/char_fifo_if.sv */
`timescale 1ns/1ns

interface char_fifo_if;

	logic wr;
	trace_pkg::record_t wdata;
	logic rd;
	trace_pkg::char_t rdata;
	logic empty;
	logic full;

	modport writer (
		output wr, wdata,
		input full, empty
	);

	modport store (
		input wr, wdata, rd,
		output rdata, empty, full
	);

	modport reader (
		output rd,
		input rdata, empty
	);

endinterface

/* design/trace_capture.sv */
`timescale 1ns/1ns

module trace_capture (
	input logic clk,
	input logic rst,
	input logic [31:0] instruction,
	input logic [31:0] data_mem_addr,
	input logic [31:0] data_mem_write_data,
	input logic data_mem_wr,
	input logic cpu_halted,
	input logic sender_idle,
	output logic halt_cpu,
	char_fifo_if.writer fifo
);

	trace_pkg::step_state_t state;
	trace_pkg::step_state_t next_state;
	logic release_cpu;
	trace_pkg::char_t wr_flag_char;

	function automatic trace_pkg::char_t hex_char(input trace_pkg::nibble_t n);
		if (n < 4'd10)
			return trace_pkg::CHAR_ZERO + {4'h0, n};
		return trace_pkg::CHAR_ALPHA_BASE + {4'h0, n};
	endfunction

	// Most significant nibble lands in the top byte
	function automatic trace_pkg::record_t hex_record(input logic [31:0] value);
		trace_pkg::record_t rec;
		for (int i = 0; i < 8; i++) begin
			rec[i*8 +: 8] = hex_char(value[i*4 +: 4]);
		end
		return rec;
	endfunction

	// Only step when everything downstream has drained
	assign release_cpu = (state == trace_pkg::IDLE) && fifo.empty && sender_idle
		&& !cpu_halted;
	assign halt_cpu = !release_cpu;

	assign wr_flag_char = trace_pkg::CHAR_ZERO | {7'b0, data_mem_wr};

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			state <= trace_pkg::IDLE;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = trace_pkg::IDLE;
		case (state)
			trace_pkg::IDLE: next_state = release_cpu ? trace_pkg::INSTR : trace_pkg::IDLE;
			trace_pkg::INSTR: next_state = trace_pkg::ADDR;
			trace_pkg::ADDR: next_state = trace_pkg::DATA;
			trace_pkg::DATA: next_state = trace_pkg::TAIL;
			default: next_state = trace_pkg::IDLE;
		endcase
	end

	assign fifo.wr = (state != trace_pkg::IDLE);

	always_comb begin
		case (state)
			trace_pkg::INSTR: fifo.wdata = hex_record(instruction);
			trace_pkg::ADDR: fifo.wdata = hex_record(data_mem_addr);
			trace_pkg::DATA: fifo.wdata = hex_record(data_mem_write_data);
			trace_pkg::TAIL: fifo.wdata = {{5{trace_pkg::CHAR_ZERO}}, wr_flag_char,
				trace_pkg::CHAR_CR, trace_pkg::CHAR_LF};
			default: fifo.wdata = '0;
		endcase
	end

	a_no_write_when_full: assert property (
		@(posedge clk) disable iff (rst) fifo.wr |-> !fifo.full
	) else $error("record written to a full FIFO");

	// CPU must stay frozen while the fields are sampled
	a_fields_stable: assert property (
		@(posedge clk) disable iff (rst)
		(state inside {trace_pkg::ADDR, trace_pkg::DATA, trace_pkg::TAIL})
		|-> $stable({instruction, data_mem_addr, data_mem_write_data, data_mem_wr})
	) else $error("CPU fields changed during capture");

endmodule

/* design/char_fifo.sv */
`timescale 1ns/1ns
`include "trace_cfg.svh"

module char_fifo (
	input logic clk,
	input logic rst,
	char_fifo_if.store fifo
);

	localparam int RECORDS = `TRACE_FIFO_RECORDS;
	localparam int REC_CHARS = 8;
	localparam int CHARS = RECORDS * REC_CHARS;
	localparam int WP_W = $clog2(RECORDS);
	localparam int RP_W = $clog2(CHARS);
	localparam int CNT_W = $clog2(CHARS + 1);

	trace_pkg::record_t mem [RECORDS];
	logic [WP_W-1:0] wr_ptr;
	// Upper bits pick the record, low three the byte
	logic [RP_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	trace_pkg::record_t cur_rec;
	logic [2:0] byte_sel;

	always_ff @(posedge clk) begin
		if (fifo.wr)
			mem[wr_ptr] <= fifo.wdata;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (fifo.wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (fifo.rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({fifo.wr, fifo.rd})
				2'b10: count <= count + CNT_W'(REC_CHARS);
				2'b01: count <= count - 1'b1;
				2'b11: count <= count + CNT_W'(REC_CHARS - 1);
				default: count <= count;
			endcase
		end
	end

	// Show-ahead, top byte first
	assign cur_rec = mem[rd_ptr[RP_W-1:3]];
	assign byte_sel = ~rd_ptr[2:0];
	assign fifo.rdata = cur_rec[{byte_sel, 3'b000} +: 8];

	assign fifo.empty = (count == '0);
	// Full means no room for another whole record
	assign fifo.full = (count > CNT_W'(CHARS - REC_CHARS));

	a_no_read_when_empty: assert property (
		@(posedge clk) disable iff (rst) fifo.rd |-> !fifo.empty
	) else $error("character read from an empty FIFO");

	a_count_bound: assert property (
		@(posedge clk) disable iff (rst) count <= CNT_W'(CHARS)
	) else $error("FIFO count over capacity");

endmodule

/* design/uart_tx.sv */
`timescale 1ns/1ns
`include "trace_cfg.svh"

module uart_tx (
	input logic clk,
	input logic rst,
	input logic start,
	input trace_pkg::char_t data,
	output logic busy,
	output logic tx
);

	localparam int BIT_W = $clog2(uart_pkg::FRAME_BITS);

	uart_pkg::tx_state_t state;
	logic [15:0] baud_cnt;
	logic [BIT_W-1:0] bit_cnt;
	logic [uart_pkg::FRAME_BITS-1:0] shift;
	logic baud_tick;

	assign baud_tick = (baud_cnt == `TRACE_BAUD_DIV - 16'd1);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= uart_pkg::TX_IDLE;
			baud_cnt <= '0;
			bit_cnt <= '0;
			shift <= '1;
		end else begin
			case (state)
				uart_pkg::TX_IDLE: begin
					if (start) begin
						// Stop, data, start; shifted out from bit 0
						shift <= {1'b1, data, 1'b0};
						baud_cnt <= '0;
						bit_cnt <= '0;
						state <= uart_pkg::TX_SHIFT;
					end
				end
				uart_pkg::TX_SHIFT: begin
					if (baud_tick) begin
						baud_cnt <= '0;
						shift <= {1'b1, shift[uart_pkg::FRAME_BITS-1:1]};
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == BIT_W'(uart_pkg::FRAME_BITS - 2))
							state <= uart_pkg::TX_STOP;
					end else begin
						baud_cnt <= baud_cnt + 16'd1;
					end
				end
				default: begin
					if (baud_tick) begin
						baud_cnt <= '0;
						state <= uart_pkg::TX_IDLE;
					end else begin
						baud_cnt <= baud_cnt + 16'd1;
					end
				end
			endcase
		end
	end

	assign busy = (state != uart_pkg::TX_IDLE);
	assign tx = shift[0];

endmodule

/* design/trace_sender.sv */
`timescale 1ns/1ns
`include "trace_cfg.svh"

module trace_sender (
	input logic clk,
	input logic rst,
	char_fifo_if.reader fifo,
	output logic sender_idle,
	output logic tx
);

	uart_pkg::send_state_t state;
	logic [31:0] gap_cnt;
	trace_pkg::char_t tx_byte;
	logic start;
	logic busy;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= uart_pkg::SEND_IDLE;
			gap_cnt <= '0;
		end else begin
			case (state)
				uart_pkg::SEND_IDLE: begin
					gap_cnt <= '0;
					if (!fifo.empty && !busy)
						state <= uart_pkg::SEND_GAP;
				end
				uart_pkg::SEND_GAP: begin
					gap_cnt <= gap_cnt + 32'd1;
					if (gap_cnt == `TRACE_GAP_CYCLES - 32'd1)
						state <= uart_pkg::SEND_POP;
				end
				uart_pkg::SEND_POP: state <= uart_pkg::SEND_START;
				default: state <= uart_pkg::SEND_IDLE;
			endcase
		end
	end

	// Byte held for the transmitter load
	always_ff @(posedge clk) begin
		if (state == uart_pkg::SEND_POP)
			tx_byte <= fifo.rdata;
	end

	assign fifo.rd = (state == uart_pkg::SEND_POP);
	assign start = (state == uart_pkg::SEND_START);
	assign sender_idle = (state == uart_pkg::SEND_IDLE) && !busy;

	uart_tx u_tx (
		.clk(clk),
		.rst(rst),
		.start(start),
		.data(tx_byte),
		.busy(busy),
		.tx(tx)
	);

	a_start_when_free: assert property (
		@(posedge clk) disable iff (rst) start |-> !busy
	) else $error("transmitter started while busy");

endmodule

/* design/cpu_trace.sv */
`timescale 1ns/1ns

module cpu_trace (
	input logic clk,
	input logic rst,
	input logic [31:0] instruction,
	input logic [31:0] data_mem_addr,
	input logic [31:0] data_mem_write_data,
	input logic data_mem_wr,
	input logic cpu_halted,
	output logic tx,
	output logic halt_cpu
);

	logic sender_idle;

	char_fifo_if fifo_bus ();

	trace_capture u_capture (
		.clk(clk),
		.rst(rst),
		.instruction(instruction),
		.data_mem_addr(data_mem_addr),
		.data_mem_write_data(data_mem_write_data),
		.data_mem_wr(data_mem_wr),
		.cpu_halted(cpu_halted),
		.sender_idle(sender_idle),
		.halt_cpu(halt_cpu),
		.fifo(fifo_bus.writer)
	);

	char_fifo u_fifo (
		.clk(clk),
		.rst(rst),
		.fifo(fifo_bus.store)
	);

	// Sender idle gates the next CPU step
	trace_sender u_sender (
		.clk(clk),
		.rst(rst),
		.fifo(fifo_bus.reader),
		.sender_idle(sender_idle),
		.tx(tx)
	);

endmodule

/* dv/cpu_trace_tb.sv */
`timescale 1ns/1ns
`include "trace_cfg.svh"

module cpu_trace_tb;

	localparam int BAUD_DIV = `TRACE_BAUD_DIV;
	localparam int GAP = `TRACE_GAP_CYCLES;
	localparam int NUM_STEPS = 40;
	localparam int STEP_CHARS = 32;
	localparam int TIMEOUT = 5000;

	logic clk = 1'b0;
	logic rst;
	logic [31:0] instruction;
	logic [31:0] data_mem_addr;
	logic [31:0] data_mem_write_data;
	logic data_mem_wr;
	logic cpu_halted;
	logic tx;
	logic halt_cpu;

	trace_pkg::char_t expect_q[$];
	logic flag_q[$];
	int rx_count = 0;

	cpu_trace uut (
		.clk(clk),
		.rst(rst),
		.instruction(instruction),
		.data_mem_addr(data_mem_addr),
		.data_mem_write_data(data_mem_write_data),
		.data_mem_wr(data_mem_wr),
		.cpu_halted(cpu_halted),
		.tx(tx),
		.halt_cpu(halt_cpu)
	);

	always #50 clk = ~clk;

	task automatic abort_run();
		$display("tests failed");
		$fatal(1, "run aborted on first error");
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out waiting for %s", what);
		abort_run();
	endtask

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("FAILED at %0t ns: %s, got %0h, expected %0h", $time, what, actual,
				expected);
			abort_run();
		end
	endtask

	function automatic trace_pkg::char_t hex_digit_char(input logic [3:0] d);
		if (d < 4'd10)
			return 8'h30 + 8'(d);
		return 8'h41 + 8'(d) - 8'd10;
	endfunction

	// Three hex words, then five zeros, flag digit, CR, LF
	task automatic push_step_chars(input logic [31:0] instr, input logic [31:0] addr,
		input logic [31:0] wdata, input logic wr_flag);
		logic [31:0] fields [3];
		fields = '{instr, addr, wdata};
		for (int f = 0; f < 3; f++) begin
			for (int i = 7; i >= 0; i--) begin
				expect_q.push_back(hex_digit_char(fields[f][i*4 +: 4]));
			end
		end
		repeat (5) expect_q.push_back(8'h30);
		expect_q.push_back(wr_flag ? 8'h31 : 8'h30);
		expect_q.push_back(8'h0d);
		expect_q.push_back(8'h0a);
		flag_q.push_back(wr_flag);
	endtask

	task automatic check_tail(input int pos, input trace_pkg::char_t c);
		if (pos == 29)
			check_value(32'(c), 32'h30 + 32'(flag_q.pop_front()), "write flag digit");
		else if (pos == 30)
			check_value(32'(c), 32'h0d, "tail CR");
		else if (pos == 31)
			check_value(32'(c), 32'h0a, "tail LF");
	endtask

	initial begin : cpu_model
		logic [31:0] rnd;
		int steps;
		int halt_left;
		int idle;
		bit released;
		void'($urandom(89));
		rst = 1'b1;
		instruction = '0;
		data_mem_addr = '0;
		data_mem_write_data = '0;
		data_mem_wr = 1'b0;
		cpu_halted = 1'b0;
		steps = 0;
		halt_left = 0;
		idle = 0;
		released = 1'b0;
		repeat (10) begin
			@(negedge clk);
			check_value(32'(tx), 32'd1, "tx level during reset");
		end
		rst = 1'b0;
		while (steps < NUM_STEPS) begin
			// New CPU state after each released cycle
			if (released) begin
				instruction = $urandom;
				data_mem_addr = $urandom;
				data_mem_write_data = $urandom;
				rnd = $urandom;
				data_mem_wr = rnd[0];
				push_step_chars(instruction, data_mem_addr, data_mem_write_data, data_mem_wr);
				steps++;
				idle = 0;
			end
			if (halt_left > 0)
				halt_left--;
			else if ($urandom % 16 == 0)
				halt_left = 1 + $urandom % 30;
			cpu_halted = (halt_left > 0) || (steps >= NUM_STEPS);
			#1;
			released = !halt_cpu;
			if (released) begin
				check_value(32'(cpu_halted), 32'd0, "cpu_halted at release");
				check_value(rx_count, steps * STEP_CHARS, "characters received before release");
			end
			idle++;
			if (idle > TIMEOUT)
				report_timeout("the next CPU step");
			@(negedge clk);
		end
		idle = 0;
		while (rx_count < NUM_STEPS * STEP_CHARS) begin
			@(negedge clk);
			idle++;
			if (idle > TIMEOUT)
				report_timeout("the last characters of the trace");
		end
		check_value(32'(expect_q.size()), 32'd0, "characters never received");
		$display("all tests passed");
		$finish;
	end

	initial begin : serial_receiver
		trace_pkg::char_t rx_byte;
		trace_pkg::char_t exp_byte;
		int idle;
		bit seen_frame;
		seen_frame = 1'b0;
		idle = 0;
		while (rst !== 1'b0) begin
			@(negedge clk);
			idle++;
			if (idle > TIMEOUT)
				report_timeout("reset to be released");
		end
		forever begin
			idle = 0;
			while (tx !== 1'b0) begin
				@(negedge clk);
				idle++;
				if (idle > TIMEOUT)
					report_timeout("a start bit on tx");
			end
			// Half a stop bit and one sample cycle are not idle line time
			if (seen_frame)
				check_value(32'(idle - BAUD_DIV / 2 - 1 >= GAP), 32'd1, "gap before start bit");
			repeat (BAUD_DIV / 2 - 1) @(negedge clk);
			check_value(32'(tx), 32'd0, "start bit level");
			for (int i = 0; i < 8; i++) begin
				repeat (BAUD_DIV) @(negedge clk);
				rx_byte[i] = tx;
			end
			repeat (BAUD_DIV) @(negedge clk);
			check_value(32'(tx), 32'd1, "stop bit level");
			seen_frame = 1'b1;
			if (expect_q.size() == 0) begin
				$display("A character arrived on tx with no CPU step pending");
				abort_run();
			end
			exp_byte = expect_q.pop_front();
			check_value(32'(rx_byte), 32'(exp_byte), "received character");
			check_tail(rx_count % STEP_CHARS, rx_byte);
			rx_count++;
		end
	end

endmodule

/* sources.f */
+incdir+include
design/trace_pkg.sv
design/uart_pkg.sv
design/char_fifo_if.sv
design/trace_capture.sv
design/char_fifo.sv
design/uart_tx.sv
design/trace_sender.sv
design/cpu_trace.sv
dv/cpu_trace_tb.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert --top-module cpu_trace_tb -f sources.f -o cpu_trace_sim \
	&& ./obj_dir/cpu_trace_sim > sim.log 2>&1 \
	|| echo "tests failed" >> sim.log
cat sim.log
grep -q "tests failed" sim.log && exit 1 || exit 0
